// File: energy_monitor.f
energy_cfg_pkg.sv
energy_types_pkg.sv
bp_pipe.sv
energy_ctrl.sv
partial_energy_calc.sv
energy_accumulator.sv
energy_monitor.sv
energy_monitor_assert.sv
tb_energy_monitor.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the energy monitor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f energy_monitor.f \
    --top-module tb_energy_monitor --Mdir obj_dir -o tb_energy_monitor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_energy_monitor > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "No result line in $LOG"
    exit 1
fi
exit 0

// File: tb_energy_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Energy monitor testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_energy_monitor;

    import energy_cfg_pkg::*;
    import energy_types_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int SEL_SPIN = 0;
    localparam int SEL_WEIGHT = 1;
    localparam int SEL_ENERGY = 2;

    logic                     clk_i, rst_n_i, en_i;
    logic                     spin_valid_i, weight_valid_i, energy_ready_i;
    spin_vec_t                spin_i;
    weight_word_t             weight_i;
    hbias_t [PARALLELISM-1:0] hbias_i;
    hscale_t [PARALLELISM-1:0] hscaling_i;
    logic                     spin_ready_o, weight_ready_o, energy_valid_o;
    energy_t                  energy_o;

    // Current frame, shared by the drivers and the reference model
    spin_vec_t                 frame_spin;
    weight_word_t              frame_w [ROWS_PER_FRAME];
    hbias_t [PARALLELISM-1:0]  frame_h [ROWS_PER_FRAME];
    hscale_t [PARALLELISM-1:0] frame_c [ROWS_PER_FRAME];

    int errors;
    int checks;
    int test_base;

    energy_monitor dut0 (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(en_i),
        .spin_valid_i(spin_valid_i), .spin_i(spin_i), .spin_ready_o(spin_ready_o),
        .weight_valid_i(weight_valid_i), .weight_i(weight_i),
        .hbias_i(hbias_i), .hscaling_i(hscaling_i), .weight_ready_o(weight_ready_o),
        .energy_valid_o(energy_valid_o), .energy_ready_i(energy_ready_i),
        .energy_o(energy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Frame energy straight from the Ising rule, spin bit 1 is +1
    function automatic energy_t ref_energy();
        int total;
        int field;
        int sigma_i;
        int sigma_j;
        int w;
        total = 0;
        for (int r = 0; r < DATASPIN; r++) begin
            // Row r sits in word r/2, slot r%2
            field = int'(frame_h[r / PARALLELISM][r % PARALLELISM])
                  * int'(frame_c[r / PARALLELISM][r % PARALLELISM]);
            for (int j = 0; j < DATASPIN; j++) begin
                sigma_j = frame_spin[j] ? 1 : -1;
                w = int'($signed(frame_w[r / PARALLELISM][r % PARALLELISM][j]));
                field = field + w * sigma_j;
            end
            sigma_i = frame_spin[r] ? 1 : -1;
            total = total + sigma_i * field;
        end
        return energy_t'(total);
    endfunction

    task automatic check_energy(input string name, input energy_t actual,
                                input energy_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Test failed");
        $finish;
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            SEL_SPIN:   return spin_ready_o;
            SEL_WEIGHT: return weight_ready_o;
            default:    return energy_valid_o;
        endcase
    endfunction

    // Polls at the falling edge, where DUT outputs are settled
    task automatic wait_high(input int sel, input string what);
        int count;
        count = 0;
        @(negedge clk_i);
        while (!probe(sel)) begin
            count++;
            if (count > TIMEOUT) abort_run({"timeout waiting for ", what});
            @(negedge clk_i);
        end
    endtask

    // Ready seen high, so the transfer lands on the next rising edge
    task automatic handshake_in(input int sel, input string what);
        wait_high(sel, what);
        @(posedge clk_i);
        #1;
    endtask

    task automatic fill_const(input logic spin_bit, input int w, input int h, input int c);
        frame_spin = {DATASPIN{spin_bit}};
        for (int k = 0; k < ROWS_PER_FRAME; k++) begin
            for (int p = 0; p < PARALLELISM; p++) begin
                frame_h[k][p] = hbias_t'(h);
                frame_c[k][p] = hscale_t'(c);
                for (int j = 0; j < DATASPIN; j++) frame_w[k][p][j] = BITJ'(w);
            end
        end
    endtask

    task automatic fill_random();
        frame_spin = spin_vec_t'($urandom());
        for (int k = 0; k < ROWS_PER_FRAME; k++) begin
            for (int p = 0; p < PARALLELISM; p++) begin
                frame_h[k][p] = hbias_t'($urandom());
                frame_c[k][p] = hscale_t'($urandom());
                for (int j = 0; j < DATASPIN; j++) frame_w[k][p][j] = BITJ'($urandom());
            end
        end
    endtask

    // Enable dropped with a weight word on offer, nothing may move
    task automatic pause_enable(input int cycles);
        en_i = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk_i);
            check_flag("weight_ready_o", weight_ready_o, 1'b0);
            check_flag("spin_ready_o", spin_ready_o, 1'b0);
            check_flag("energy_valid_o", energy_valid_o, 1'b0);
            @(posedge clk_i);
            #1;
        end
        en_i = 1'b1;
    endtask

    // One spin vector, then eight weight words, optional pause before one word
    task automatic send_frame(input int pause_word);
        spin_i = frame_spin;
        spin_valid_i = 1'b1;
        handshake_in(SEL_SPIN, "spin_ready_o");
        spin_valid_i = 1'b0;
        for (int k = 0; k < ROWS_PER_FRAME; k++) begin
            weight_i = frame_w[k];
            hbias_i = frame_h[k];
            hscaling_i = frame_c[k];
            weight_valid_i = 1'b1;
            if (k == pause_word) pause_enable(6);
            handshake_in(SEL_WEIGHT, "weight_ready_o");
        end
        weight_valid_i = 1'b0;
    endtask

    // Stall of zero expects energy_ready_i already high
    task automatic collect_energy(input energy_t expected, input int stall);
        energy_t held;
        wait_high(SEL_ENERGY, "energy_valid_o");
        check_energy("energy_o", energy_o, expected);
        held = energy_o;
        for (int n = 0; n < stall; n++) begin
            @(posedge clk_i);
            #1;
            @(negedge clk_i);
            check_flag("energy_valid_o", energy_valid_o, 1'b1);
            check_flag("spin_ready_o", spin_ready_o, 1'b0);
            check_energy("energy_o", energy_o, held);
        end
        @(posedge clk_i);
        #1;
        if (stall > 0) begin
            energy_ready_i = 1'b1;
            @(posedge clk_i);
            #1;
            energy_ready_i = 1'b0;
            // Spin input opens again once the result is taken
            wait_high(SEL_SPIN, "spin_ready_o after acceptance");
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s finished, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic test_all_up();
        energy_ready_i = 1'b1;
        fill_const(1'b1, 1, 1, 1);
        check_energy("reference energy", ref_energy(), energy_t'(272));
        send_frame(-1);
        collect_energy(ref_energy(), 0);
        report_test("all spins up");
    endtask

    task automatic test_all_down();
        energy_ready_i = 1'b1;
        fill_const(1'b0, -7, -7, 15);
        send_frame(-1);
        collect_energy(ref_energy(), 0);
        report_test("all spins down");
    endtask

    task automatic test_random_frames();
        energy_ready_i = 1'b1;
        for (int f = 0; f < 20; f++) begin
            fill_random();
            send_frame(-1);
            collect_energy(ref_energy(), 0);
        end
        report_test("random frames");
    endtask

    task automatic test_backpressure();
        energy_ready_i = 1'b0;
        fill_random();
        send_frame(-1);
        collect_energy(ref_energy(), 20);
        energy_ready_i = 1'b1;
        report_test("back-pressure");
    endtask

    task automatic test_enable_pause();
        energy_ready_i = 1'b1;
        fill_random();
        send_frame(4);
        collect_energy(ref_energy(), 0);
        report_test("enable pause");
    endtask

    // Reset hits while a finished result is still held
    task automatic test_reset_state();
        energy_ready_i = 1'b0;
        fill_random();
        send_frame(-1);
        wait_high(SEL_ENERGY, "energy_valid_o before reset");
        @(posedge clk_i);
        #1;
        rst_n_i = 1'b0;
        for (int n = 0; n < 3; n++) begin
            @(posedge clk_i);
            #1;
            check_flag("energy_valid_o", energy_valid_o, 1'b0);
            check_flag("weight_ready_o", weight_ready_o, 1'b0);
            check_flag("spin_ready_o", spin_ready_o, 1'b0);
        end
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_flag("energy_valid_o", energy_valid_o, 1'b0);
        check_flag("weight_ready_o", weight_ready_o, 1'b0);
        wait_high(SEL_SPIN, "spin_ready_o after reset");
        @(posedge clk_i);
        #1;
        // Next frame must start from a cleared sum
        energy_ready_i = 1'b1;
        fill_random();
        send_frame(-1);
        collect_energy(ref_energy(), 0);
        report_test("reset state");
    endtask

    initial begin
        errors = 0;
        checks = 0;
        test_base = 0;
        $timeformat(-9, 0, "", 0);
        void'($urandom(9));
        rst_n_i = 1'b0;
        en_i = 1'b1;
        spin_valid_i = 1'b0;
        spin_i = '0;
        weight_valid_i = 1'b0;
        weight_i = '0;
        hbias_i = '0;
        hscaling_i = '0;
        energy_ready_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        test_all_up();
        test_all_down();
        test_random_frames();
        test_backpressure();
        test_enable_pause();
        test_reset_state();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: energy_monitor_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Energy monitor handshake assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module energy_monitor_assert (
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      spin_valid_i,
    input logic                      weight_valid_i,
    input logic                      spin_ready_i,
    input logic                      weight_ready_i,
    input logic                      energy_valid_i,
    input logic                      energy_ready_i,
    input energy_types_pkg::energy_t energy_i
);

    // Held result keeps its value until the consumer takes it
    a_energy_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        energy_valid_i && !energy_ready_i |=> energy_valid_i && $stable(energy_i))
        else $error("energy_o changed or dropped while stalled");

    // Spin phase and row phase never overlap
    a_ready_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(spin_ready_i && weight_ready_i))
        else $error("spin_ready_o and weight_ready_o both high");

    // Reset edge clears the result flag
    a_reset_energy_valid: assert property (@(posedge clk_i)
        !rst_n_i |=> !energy_valid_i)
        else $error("energy_valid_o high after a reset edge");

    a_reset_inputs: assert property (@(posedge clk_i)
        !rst_n_i |-> !spin_valid_i && !weight_valid_i)
        else $error("input valid high during reset");

endmodule

bind energy_monitor energy_monitor_assert u_assert (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .spin_valid_i(spin_valid_i), .weight_valid_i(weight_valid_i),
    .spin_ready_i(spin_ready_o), .weight_ready_i(weight_ready_o),
    .energy_valid_i(energy_valid_o), .energy_ready_i(energy_ready_i),
    .energy_i(energy_o)
);

// File: energy_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ising energy monitor top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module energy_monitor (
    input  logic                                                     clk_i,
    input  logic                                                     rst_n_i,
    input  logic                                                     en_i,
    input  logic                                                     spin_valid_i,
    input  energy_types_pkg::spin_vec_t                              spin_i,
    output logic                                                     spin_ready_o,
    input  logic                                                     weight_valid_i,
    input  energy_types_pkg::weight_word_t                           weight_i,
    input  energy_types_pkg::hbias_t [energy_cfg_pkg::PARALLELISM-1:0]  hbias_i,
    input  energy_types_pkg::hscale_t [energy_cfg_pkg::PARALLELISM-1:0] hscaling_i,
    output logic                                                     weight_ready_o,
    output logic                                                     energy_valid_o,
    input  logic                                                     energy_ready_i,
    output energy_types_pkg::energy_t                                energy_o
);

    import energy_cfg_pkg::*;
    import energy_types_pkg::*;

    spin_vec_t                spin_pipe, spin_cached;
    weight_pkt_t              weight_pkt_in, weight_pkt_pipe;
    logic                     spin_pipe_valid, spin_pipe_ready, spin_take;
    logic                     weight_pipe_valid, weight_pipe_ready, weight_take;
    logic                     row_valid, row_last, frame_done, clear;
    logic [PARALLELISM-1:0]   current_spin, exe_valid, exe_last;
    local_energy_t            local_energy [PARALLELISM];

    // Pipe inputs only open in the matching controller phase
    assign spin_ready_o = spin_pipe_ready && spin_take;
    assign weight_ready_o = weight_pipe_ready && weight_take;
    assign weight_pkt_in = '{weight: weight_i, hbias: hbias_i, hscaling: hscaling_i};

    bp_pipe #(.payload_t(spin_vec_t), .PIPES(PIPESINTF)) u_pipe_spin (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .valid_i(spin_valid_i && spin_take), .data_i(spin_i), .ready_o(spin_pipe_ready),
        .valid_o(spin_pipe_valid), .data_o(spin_pipe), .ready_i(spin_take)
    );

    bp_pipe #(.payload_t(weight_pkt_t), .PIPES(PIPESINTF)) u_pipe_weight (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .valid_i(weight_valid_i && weight_take), .data_i(weight_pkt_in),
        .ready_o(weight_pipe_ready),
        .valid_o(weight_pipe_valid), .data_o(weight_pkt_pipe), .ready_i(weight_take)
    );

    energy_ctrl u_ctrl (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(en_i),
        .spin_valid_i(spin_pipe_valid), .spin_i(spin_pipe), .spin_ready_o(spin_take),
        .weight_valid_i(weight_pipe_valid), .weight_ready_o(weight_take),
        .row_valid_o(row_valid), .row_last_o(row_last),
        .spin_vec_o(spin_cached), .current_spin_o(current_spin),
        .frame_done_i(frame_done), .clear_o(clear),
        .energy_valid_o(energy_valid_o), .energy_ready_i(energy_ready_i)
    );

    // One execute unit per row of the weight word
    for (genvar k = 0; k < PARALLELISM; k++) begin : g_exe
        partial_energy_calc u_partial_energy_calc (
            .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(en_i),
            .valid_i(row_valid), .last_i(row_last),
            .spin_vec_i(spin_cached), .current_spin_i(current_spin[k]),
            .weight_i(weight_pkt_pipe.weight[k]),
            .hbias_i(weight_pkt_pipe.hbias[k]), .hscaling_i(weight_pkt_pipe.hscaling[k]),
            .valid_o(exe_valid[k]), .last_o(exe_last[k]), .energy_o(local_energy[k])
        );
    end

    energy_accumulator u_accumulator (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(en_i),
        .valid_i(&exe_valid), .last_i(&exe_last), .clear_i(clear),
        .energy_a_i(local_energy[0]), .energy_b_i(local_energy[1]),
        .frame_done_o(frame_done), .energy_o(energy_o)
    );

endmodule

// File: energy_accumulator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame energy accumulator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module energy_accumulator (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             en_i,
    input  logic                             valid_i,
    input  logic                             last_i,
    input  logic                             clear_i,
    input  energy_types_pkg::local_energy_t  energy_a_i,
    input  energy_types_pkg::local_energy_t  energy_b_i,
    output logic                             frame_done_o,
    output energy_types_pkg::energy_t        energy_o
);

    import energy_types_pkg::*;

    energy_t pair_sum;
    energy_t sum_q;
    logic    done_q;

    // Both rows sign-extended before the add
    assign pair_sum = energy_t'(energy_a_i) + energy_t'(energy_b_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sum_q <= '0;
            done_q <= 1'b0;
        end else if (en_i) begin
            // One-cycle pulse after the last pair lands
            done_q <= valid_i && last_i;
            if (clear_i) begin
                sum_q <= '0;
            end else if (valid_i) begin
                sum_q <= sum_q + pair_sum;
            end
        end
    end

    assign frame_done_o = done_q;
    assign energy_o = sum_q;

endmodule

// File: partial_energy_calc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local energy of one row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module partial_energy_calc (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             en_i,
    input  logic                             valid_i,
    input  logic                             last_i,
    input  energy_types_pkg::spin_vec_t      spin_vec_i,
    input  logic                             current_spin_i,
    input  energy_types_pkg::weight_row_t    weight_i,
    input  energy_types_pkg::hbias_t         hbias_i,
    input  energy_types_pkg::hscale_t        hscaling_i,
    output logic                             valid_o,
    output logic                             last_o,
    output energy_types_pkg::local_energy_t  energy_o
);

    import energy_cfg_pkg::*;
    import energy_types_pkg::*;

    local_energy_t weight_sum, bias_term, row_energy, energy_d;
    local_energy_t energy_q;
    logic          valid_q, last_q;

    // Weighted spin sum, a spin of 0 subtracts its weight
    always_comb begin
        weight_sum = '0;
        for (int j = 0; j < DATASPIN; j++) begin
            if (spin_vec_i[j]) begin
                weight_sum = weight_sum + local_energy_t'($signed(weight_i[j]));
            end else begin
                weight_sum = weight_sum - local_energy_t'($signed(weight_i[j]));
            end
        end
    end

    // Signed bias times unsigned scaling, zero-extended
    assign bias_term = local_energy_t'(hbias_i) * local_energy_t'(hscaling_i);
    assign row_energy = weight_sum + bias_term;
    // Sign of the row's own spin
    assign energy_d = current_spin_i ? row_energy : -row_energy;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= valid_i;
            last_q <= valid_i && last_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && valid_i) energy_q <= energy_d;
    end

    assign valid_o = valid_q;
    assign last_o = last_q;
    assign energy_o = energy_q;

endmodule

// File: energy_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame control and spin selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module energy_ctrl (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         en_i,
    input  logic                                         spin_valid_i,
    input  energy_types_pkg::spin_vec_t                  spin_i,
    output logic                                         spin_ready_o,
    input  logic                                         weight_valid_i,
    output logic                                         weight_ready_o,
    output logic                                         row_valid_o,
    output logic                                         row_last_o,
    output energy_types_pkg::spin_vec_t                  spin_vec_o,
    output logic [energy_cfg_pkg::PARALLELISM-1:0]       current_spin_o,
    input  logic                                         frame_done_i,
    output logic                                         clear_o,
    output logic                                         energy_valid_o,
    input  logic                                         energy_ready_i
);

    import energy_cfg_pkg::*;
    import energy_types_pkg::*;

    typedef enum logic [1:0] {
        S_SPIN,
        S_ROWS,
        S_HOLD
    } state_t;

    // Index of the first spin of the last row pair
    localparam logic [SPINIDX_BIT-1:0] LAST_IDX =
        SPINIDX_BIT'((ROWS_PER_FRAME - 1) * PARALLELISM);

    state_t                 state_q, state_d;
    logic [SPINIDX_BIT-1:0] spin_idx_q;
    spin_vec_t              spin_cache_q;
    logic                   energy_valid_q;
    logic                   spin_fire, weight_fire, energy_fire;
    logic                   idx_last;

    // Readies only in their own phase, and only while enabled
    assign spin_ready_o = en_i && (state_q == S_SPIN);
    assign weight_ready_o = en_i && (state_q == S_ROWS);

    assign spin_fire = spin_valid_i && spin_ready_o;
    assign weight_fire = weight_valid_i && weight_ready_o;
    assign energy_fire = en_i && energy_valid_q && energy_ready_i;
    assign idx_last = (spin_idx_q == LAST_IDX);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_SPIN: begin
                if (spin_fire) state_d = S_ROWS;
            end
            S_ROWS: begin
                // Eighth word closes the frame input
                if (weight_fire && idx_last) state_d = S_HOLD;
            end
            S_HOLD: begin
                if (energy_fire) state_d = S_SPIN;
            end
            default: state_d = S_SPIN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_SPIN;
            spin_idx_q <= '0;
            energy_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Row counter steps by one row pair per word
            if (spin_fire) begin
                spin_idx_q <= '0;
            end else if (weight_fire) begin
                spin_idx_q <= spin_idx_q + SPINIDX_BIT'(PARALLELISM);
            end
            // Result is held until the consumer takes it
            if (en_i && (state_q == S_HOLD) && frame_done_i) begin
                energy_valid_q <= 1'b1;
            end else if (energy_fire) begin
                energy_valid_q <= 1'b0;
            end
        end
    end

    // Spin vector kept for the whole frame
    always_ff @(posedge clk_i) begin
        if (spin_fire) spin_cache_q <= spin_i;
    end

    assign row_valid_o = weight_fire;
    assign row_last_o = weight_fire && idx_last;
    assign spin_vec_o = spin_cache_q;
    // Little-endian pick of the two current spins
    assign current_spin_o = spin_cache_q[spin_idx_q +: PARALLELISM];
    assign clear_o = energy_fire;
    assign energy_valid_o = energy_valid_q;

endmodule

// File: bp_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready pipe with skid buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bp_pipe #(
    parameter type payload_t = logic,
    parameter int PIPES = 1
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    if (PIPES == 0) begin : g_bypass
        assign valid_o = valid_i;
        assign data_o = data_i;
        assign ready_o = ready_i;
    end else begin : g_chain
        // Stage boundaries, index 0 faces the input
        logic     valid_s [PIPES+1];
        logic     ready_s [PIPES+1];
        payload_t data_s [PIPES+1];

        assign valid_s[0] = valid_i;
        assign data_s[0] = data_i;
        assign ready_o = ready_s[0];
        assign valid_o = valid_s[PIPES];
        assign data_o = data_s[PIPES];
        assign ready_s[PIPES] = ready_i;

        for (genvar s = 0; s < PIPES; s++) begin : g_stage
            logic     main_valid_q, skid_valid_q, ready_q;
            logic     main_valid_d, skid_valid_d;
            logic     in_fire, drain;
            payload_t main_q, skid_q;

            assign in_fire = valid_s[s] && ready_q;
            // Main register free or emptying this cycle
            assign drain = !main_valid_q || ready_s[s+1];
            // Skid only fills while the main register is stalled
            assign skid_valid_d = drain ? 1'b0 : (skid_valid_q || in_fire);
            assign main_valid_d = drain ? (skid_valid_q || in_fire) : 1'b1;

            always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                    main_valid_q <= 1'b0;
                    skid_valid_q <= 1'b0;
                    ready_q <= 1'b0;
                end else begin
                    main_valid_q <= main_valid_d;
                    skid_valid_q <= skid_valid_d;
                    // Registered ready, high whenever the skid is empty
                    ready_q <= !skid_valid_d;
                end
            end

            always_ff @(posedge clk_i) begin
                if (drain) begin
                    main_q <= skid_valid_q ? skid_q : data_s[s];
                end
                if (!drain && in_fire) begin
                    skid_q <= data_s[s];
                end
            end

            assign ready_s[s] = ready_q;
            assign valid_s[s+1] = main_valid_q;
            assign data_s[s+1] = main_q;
        end
    end

endmodule

// File: energy_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Energy monitor data types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package energy_types_pkg;

    import energy_cfg_pkg::*;

    // One bit per spin, 1 is +1 and 0 is -1
    typedef logic [DATASPIN-1:0] spin_vec_t;

    // Row of signed weights, weight j sits at index j
    typedef logic [DATASPIN-1:0][BITJ-1:0] weight_row_t;
    // Little-endian, row 0 of the pair in the low bits
    typedef weight_row_t [PARALLELISM-1:0] weight_word_t;

    typedef logic signed [BITH-1:0] hbias_t;
    typedef logic [SCALING_BIT-1:0] hscale_t;

    // Weight pipe payload, one row pair with its biases and scalings
    typedef struct packed {
        weight_word_t weight;
        hbias_t [PARALLELISM-1:0] hbias;
        hscale_t [PARALLELISM-1:0] hscaling;
    } weight_pkt_t;

    typedef logic signed [LOCAL_ENERGY_BIT-1:0] local_energy_t;
    typedef logic signed [ENERGY_TOTAL_BIT-1:0] energy_t;

endpackage

// File: energy_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Energy monitor geometry and widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package energy_cfg_pkg;

    // Spins per frame and rows handled per weight word
    localparam int DATASPIN = 16;
    localparam int PARALLELISM = 2;
    // One weight word per row pair
    localparam int ROWS_PER_FRAME = DATASPIN / PARALLELISM;

    // Signed weight, signed bias, unsigned scaling
    localparam int BITJ = 4;
    localparam int BITH = 4;
    localparam int SCALING_BIT = 4;

    // Energy widths, local row and full frame
    localparam int LOCAL_ENERGY_BIT = 16;
    localparam int ENERGY_TOTAL_BIT = 32;

    // Spin index, wide enough for DATASPIN entries
    localparam int SPINIDX_BIT = 4;
    // Register stages in each input pipe
    localparam int PIPESINTF = 1;

endpackage
